/* filelist.f */
logic/axi_pkg.sv
logic/ram_pkg.sv
logic/req_queue.sv
logic/burst_addr_gen.sv
logic/ram_timing_model.sv
logic/ram_storage.sv
logic/ram_model_top.sv
verification/tb_ram_model.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_ram_model -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ram_model > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verification/tb_ram_model.sv */
`timescale 1ns/1ps

module tb_ram_model
    import axi_pkg::*;
    import ram_pkg::*;
();

    localparam int MEM_WORDS    = 1024;
    localparam int R_DELAY      = 25;
    localparam int W_DELAY      = 3;
    localparam int QUEUE_DEPTH  = 4;
    localparam int MEM_BYTES    = MEM_WORDS * 4;
    localparam int REGION_WORDS = 256;
    localparam int LIMIT        = 500;
    localparam int SEED         = 61;

    logic                  clk;
    logic                  resetn;
    logic                  arvalid;
    logic                  arready;
    addr_chan_t            ar;
    logic                  rvalid;
    logic                  rready;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  rlast;
    logic                  awvalid;
    logic                  awready;
    addr_chan_t            aw;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wlast;
    logic                  bvalid;
    logic                  bready;
    logic                  stall = 1'b0;

    // reference memory with one byte per key
    logic [7:0]  ref_mem [int unsigned];
    string       test_name = "reset";
    int          check_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;
    int          cycle_count = 0;
    int          stall_from = 0;
    int          stall_to = 0;
    bit          stall_random = 1'b0;

    ram_model_top UUT (
        .clk     (clk),
        .resetn  (resetn),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .stall   (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // stall comes from a window of cycles or from random draws
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        #1;
        if (cycle_count >= stall_from && cycle_count < stall_to)
            stall = 1'b1;
        else if (stall_random)
            stall = ($urandom % 5) == 0;
        else
            stall = 1'b0;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_timeout(string what);
        timeout_count++;
        $display("timeout in %s: no %s within %0d cycles", test_name, what, LIMIT);
    endtask

    // every handshake is blocked while stall is high
    always @(negedge clk) begin
        if (resetn && stall)
            check_value("outputs under stall", 32'h0,
                        {27'd0, arready, awready, wready, rvalid, bvalid});
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // beat address by the AXI burst rules
    function automatic logic [31:0] beat_addr(addr_chan_t req, int beat);
        int unsigned bytes;
        int unsigned span;
        int unsigned base;
        bytes = 32'd1 << req.size;
        if (req.burst == FIXED)
            return req.addr;
        if (req.burst == WRAP) begin
            span = bytes * (32'(req.len) + 32'd1);
            base = req.addr - (req.addr % span);
            return base + ((req.addr - base + 32'(beat) * bytes) % span);
        end
        return req.addr + 32'(beat) * bytes;
    endfunction

    task automatic model_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
        int unsigned word;
        word = (addr & ~32'd3) % MEM_BYTES;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                ref_mem[word + 32'(b)] = data[b*8 +: 8];
        end
    endtask

    function automatic logic [31:0] model_word(logic [31:0] addr);
        int unsigned word;
        logic [31:0] value;
        word = (addr & ~32'd3) % MEM_BYTES;
        value = 'x;
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(word + 32'(b)))
                value[b*8 +: 8] = ref_mem[word + 32'(b)];
        end
        return value;
    endfunction

    function automatic addr_chan_t rand_incr();
        addr_chan_t req;
        req.len   = 8'($urandom % 16);
        req.size  = 3'd2;
        req.burst = INCR;
        req.addr  = 32'(($urandom % (REGION_WORDS - 32'(req.len))) * 4);
        return req;
    endfunction

    function automatic addr_chan_t rand_wrap_fixed(bit wrap);
        addr_chan_t req;
        req.size = 3'd2;
        req.addr = 32'(($urandom % REGION_WORDS) * 4);
        if (wrap) begin
            req.burst = WRAP;
            req.len   = 8'((2 << ($urandom % 4)) - 1);
        end else begin
            req.burst = FIXED;
            req.len   = 8'($urandom % 8);
        end
        return req;
    endfunction

    task automatic issue_read(addr_chan_t req);
        int waited;
        bit accepted;
        waited = 0;
        accepted = 1'b0;
        ar = req;
        arvalid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = arready;
            next_cycle();
            waited++;
            if (!accepted && waited > LIMIT) begin
                report_timeout("arready");
                break;
            end
        end
        arvalid = 1'b0;
    endtask

    task automatic issue_write(addr_chan_t req);
        int waited;
        bit accepted;
        waited = 0;
        accepted = 1'b0;
        aw = req;
        awvalid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = awready;
            next_cycle();
            waited++;
            if (!accepted && waited > LIMIT) begin
                report_timeout("awready");
                break;
            end
        end
        awvalid = 1'b0;
    endtask

    task automatic send_w_beats(addr_chan_t req, bit rand_strb);
        int waited;
        bit accepted;
        for (int beat = 0; beat <= int'(req.len); beat++) begin
            wdata = $urandom;
            wstrb = rand_strb ? 4'($urandom) : 4'hf;
            wlast = (beat == int'(req.len));
            wvalid = 1'b1;
            accepted = 1'b0;
            waited = 0;
            while (!accepted) begin
                @(negedge clk);
                accepted = wready;
                if (accepted)
                    model_write(beat_addr(req, beat), wdata, wstrb);
                next_cycle();
                waited++;
                if (!accepted && waited > LIMIT) begin
                    report_timeout("wready");
                    break;
                end
            end
        end
        wvalid = 1'b0;
        wlast = 1'b0;
    endtask

    // cycles counted from the wlast handshake edge to the first bvalid
    task automatic wait_bresp(bit back_pressure, output int first_cycles);
        int cycles;
        bit done;
        cycles = 0;
        done = 1'b0;
        first_cycles = -1;
        while (!done) begin
            bready = back_pressure ? 1'($urandom) : 1'b1;
            @(negedge clk);
            cycles++;
            if (first_cycles >= 0 && !stall)
                check_value("bvalid held until bready", 32'h1, 32'(bvalid));
            if (bvalid && first_cycles < 0)
                first_cycles = cycles;
            done = bvalid && bready;
            next_cycle();
            if (!done && cycles > LIMIT) begin
                report_timeout("write response");
                break;
            end
        end
        bready = 1'b0;
    endtask

    task automatic collect_read(addr_chan_t req, bit back_pressure, output int first_cycles);
        int beat;
        int cycles;
        int waited;
        bit holding;
        logic [31:0] held_data;
        logic held_last;
        beat = 0;
        cycles = 0;
        waited = 0;
        holding = 1'b0;
        first_cycles = -1;
        while (beat <= int'(req.len)) begin
            rready = back_pressure ? 1'($urandom) : 1'b1;
            @(negedge clk);
            cycles++;
            waited++;
            if (rvalid) begin
                if (first_cycles < 0)
                    first_cycles = cycles;
                if (holding) begin
                    check_value("rdata held", held_data, rdata);
                    check_value("rlast held", 32'(held_last), 32'(rlast));
                end
                if (rready) begin
                    check_value($sformatf("rdata beat %0d", beat),
                                model_word(beat_addr(req, beat)), rdata);
                    check_value("rlast", 32'(beat == int'(req.len)), 32'(rlast));
                    beat++;
                    waited = 0;
                    holding = 1'b0;
                end else begin
                    holding = 1'b1;
                    held_data = rdata;
                    held_last = rlast;
                end
            end
            next_cycle();
            if (waited > LIMIT) begin
                report_timeout("read beat");
                break;
            end
        end
        rready = 1'b0;
    endtask

    task automatic write_burst(addr_chan_t req, bit rand_strb, bit back_pressure,
                               output int b_cycles);
        issue_write(req);
        send_w_beats(req, rand_strb);
        wait_bresp(back_pressure, b_cycles);
    endtask

    task automatic read_burst(addr_chan_t req, bit back_pressure, output int first_cycles);
        issue_read(req);
        collect_read(req, back_pressure, first_cycles);
    endtask

    initial begin
        addr_chan_t req;
        addr_chan_t win;
        addr_chan_t list [$];
        int lat;
        int n;
        void'($urandom(SEED));
        resetn = 1'b0;
        arvalid = 1'b0;
        ar = '0;
        rready = 1'b0;
        awvalid = 1'b0;
        aw = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        bready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check_value("idle after reset", 32'b11000,
                    {27'd0, arready, awready, wready, rvalid, bvalid});
        next_cycle();

        // full-strobe fill so every read address is known
        test_name = "init";
        for (int i = 0; i < REGION_WORDS / 16; i++) begin
            req = '{addr: 32'(i * 64), len: 8'd15, size: 3'd2, burst: INCR};
            write_burst(req, 1'b0, 1'b0, lat);
        end

        test_name = "incr_bursts";
        for (int i = 0; i < 12; i++) begin
            req = rand_incr();
            list.push_back(req);
            write_burst(req, 1'b1, 1'b0, lat);
        end
        foreach (list[i])
            read_burst(list[i], 1'b0, lat);

        test_name = "fixed_wrap";
        for (int i = 0; i < 10; i++) begin
            req = rand_wrap_fixed(i % 2 == 1);
            write_burst(req, 1'b1, 1'b0, lat);
            read_burst(req, 1'b0, lat);
            // same bytes read back in plain address order
            win = req;
            win.burst = INCR;
            if (req.burst == WRAP)
                win.addr = req.addr - (req.addr % ((32'(req.len) + 32'd1) * 32'd4));
            else
                win.len = 8'd0;
            read_burst(win, 1'b0, lat);
        end

        test_name = "latency";
        req = '{addr: 32'h40, len: 8'd0, size: 3'd2, burst: INCR};
        read_burst(req, 1'b0, lat);
        check_value("first rvalid after AR", 32'(R_DELAY + 1), 32'(lat));
        write_burst(req, 1'b0, 1'b0, lat);
        check_value("bvalid after wlast", 32'(W_DELAY), 32'(lat));

        test_name = "back_pressure";
        list.delete();
        for (int i = 0; i < 8; i++) begin
            req = rand_incr();
            list.push_back(req);
            write_burst(req, 1'b1, 1'b1, lat);
        end
        foreach (list[i])
            read_burst(list[i], 1'b1, lat);

        test_name = "stall_latency";
        n = 1 + int'($urandom % 10);
        req = rand_incr();
        issue_read(req);
        stall_from = cycle_count + 4;
        stall_to = stall_from + n;
        collect_read(req, 1'b0, lat);
        check_value("stalled read latency", 32'(R_DELAY + 1 + n), 32'(lat));
        n = 1 + int'($urandom % 4);
        issue_write(req);
        send_w_beats(req, 1'b1);
        stall_from = cycle_count + 1;
        stall_to = stall_from + n;
        wait_bresp(1'b0, lat);
        check_value("stalled write latency", 32'(W_DELAY + n), 32'(lat));

        test_name = "random_stall";
        stall_random = 1'b1;
        list.delete();
        for (int i = 0; i < 6; i++) begin
            req = rand_incr();
            list.push_back(req);
            write_burst(req, 1'b1, 1'b1, lat);
        end
        foreach (list[i])
            read_burst(list[i], 1'b1, lat);
        stall_random = 1'b0;
        next_cycle();
        next_cycle();

        // one burst in flight plus a full queue blocks the next AR
        test_name = "queued_reads";
        list.delete();
        for (int i = 0; i < QUEUE_DEPTH + 2; i++)
            list.push_back(rand_incr());
        fork
            begin
                for (int i = 0; i < QUEUE_DEPTH + 2; i++) begin
                    issue_read(list[i]);
                    if (i == QUEUE_DEPTH) begin
                        @(negedge clk);
                        check_value("arready with full queue", 32'h0, 32'(arready));
                        next_cycle();
                    end
                end
            end
            begin
                for (int i = 0; i < QUEUE_DEPTH + 2; i++)
                    collect_read(list[i], 1'b1, lat);
            end
        join

        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* logic/ram_model_top.sv */
`timescale 1ns/1ps

module ram_model_top
    import axi_pkg::*;
    import ram_pkg::*;
#(
    parameter int MEM_WORDS   = 1024,
    parameter int R_DELAY     = 25,
    parameter int W_DELAY     = 3,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic                  arvalid,
    output logic                  arready,
    input  addr_chan_t            ar,

    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rlast,

    input  logic                  awvalid,
    output logic                  awready,
    input  addr_chan_t            aw,

    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  wlast,

    output logic                  bvalid,
    input  logic                  bready,

    input  logic                  stall
);

    logic                  rd_full;
    logic                  rd_not_empty;
    burst_desc_t           rd_head;
    logic                  rd_pop;
    logic                  rd_step;
    logic [ADDR_WIDTH-1:0] rd_addr;

    logic                  wr_full;
    logic                  wr_not_empty;
    burst_desc_t           wr_head;
    logic                  wr_pop;
    logic                  wr_step;
    logic [ADDR_WIDTH-1:0] wr_addr;

    assign arready = !rd_full && !stall;
    assign awready = !wr_full && !stall;

    req_queue #(
        .entry_t (burst_desc_t),
        .DEPTH   (QUEUE_DEPTH)
    ) rd_queue (
        .clk       (clk),
        .resetn    (resetn),
        .push      (arvalid && arready),
        .push_data (to_desc(ar)),
        .pop       (rd_pop),
        .head      (rd_head),
        .full      (rd_full),
        .not_empty (rd_not_empty)
    );

    req_queue #(
        .entry_t (burst_desc_t),
        .DEPTH   (QUEUE_DEPTH)
    ) wr_queue (
        .clk       (clk),
        .resetn    (resetn),
        .push      (awvalid && awready),
        .push_data (to_desc(aw)),
        .pop       (wr_pop),
        .head      (wr_head),
        .full      (wr_full),
        .not_empty (wr_not_empty)
    );

    // generators load the queue head on the pop
    burst_addr_gen rd_addr_gen (
        .clk    (clk),
        .resetn (resetn),
        .load   (rd_pop),
        .desc   (rd_head),
        .step   (rd_step),
        .addr   (rd_addr)
    );

    burst_addr_gen wr_addr_gen (
        .clk    (clk),
        .resetn (resetn),
        .load   (wr_pop),
        .desc   (wr_head),
        .step   (wr_step),
        .addr   (wr_addr)
    );

    ram_timing_model #(
        .R_DELAY (R_DELAY),
        .W_DELAY (W_DELAY)
    ) timing (
        .clk         (clk),
        .resetn      (resetn),
        .stall       (stall),
        .rd_pending  (rd_not_empty),
        .wr_pending  (wr_not_empty),
        .rd_head_len (rd_head.len),
        .wr_head_len (wr_head.len),
        .rd_pop      (rd_pop),
        .wr_pop      (wr_pop),
        .rvalid      (rvalid),
        .rready      (rready),
        .rlast       (rlast),
        .wvalid      (wvalid),
        .wlast       (wlast),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .rd_step     (rd_step),
        .wr_step     (wr_step)
    );

    // write enable is the W handshake
    ram_storage #(
        .MEM_WORDS (MEM_WORDS)
    ) storage (
        .clk   (clk),
        .we    (wr_step),
        .waddr (wr_addr),
        .raddr (rd_addr),
        .wdata (wdata),
        .wstrb (wstrb),
        .rdata (rdata)
    );

endmodule

/* logic/ram_storage.sv */
`timescale 1ns/1ps

module ram_storage
    import axi_pkg::*;
    import ram_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    output logic [DATA_WIDTH-1:0] rdata
);

    localparam int OFFS  = $clog2(STRB_WIDTH);
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [ADDR_WIDTH-1:0] wword;
    logic [ADDR_WIDTH-1:0] rword;
    logic [IDX_W-1:0]      widx;
    logic [IDX_W-1:0]      ridx;

    // byte address to word index modulo the depth
    assign wword = (waddr >> OFFS) % ADDR_WIDTH'(MEM_WORDS);
    assign rword = (raddr >> OFFS) % ADDR_WIDTH'(MEM_WORDS);
    assign widx  = wword[IDX_W-1:0];
    assign ridx  = rword[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b])
                    mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    assign rdata = mem[ridx];

endmodule

/* logic/ram_timing_model.sv */
`timescale 1ns/1ps

module ram_timing_model #(
    parameter int R_DELAY = 25,
    parameter int W_DELAY = 3
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       stall,
    input  logic       rd_pending,
    input  logic       wr_pending,
    input  logic [7:0] rd_head_len,
    input  logic [7:0] wr_head_len,
    output logic       rd_pop,
    output logic       wr_pop,
    output logic       rvalid,
    input  logic       rready,
    output logic       rlast,
    input  logic       wvalid,
    input  logic       wlast,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready,
    output logic       rd_step,
    output logic       wr_step
);

    // the pop cycle itself counts as the first delay cycle
    localparam logic [15:0] R_LOAD = 16'((R_DELAY > 0) ? R_DELAY - 1 : 0);
    localparam logic [15:0] W_LOAD = 16'((W_DELAY > 0) ? W_DELAY - 1 : 0);

    logic        rd_active;
    logic [7:0]  rd_left;
    logic [15:0] rd_cnt;

    logic        wr_active;
    logic [7:0]  wr_left;
    logic        wr_done;
    logic [15:0] wr_cnt;
    logic        wr_end;

    // read side
    assign rd_pop  = rd_pending && !rd_active && !stall;
    assign rvalid  = rd_active && (rd_cnt == 16'd0) && !stall;
    assign rlast   = rd_active && (rd_left == 8'd0);
    assign rd_step = rvalid && rready;

    // write side
    assign wr_pop  = wr_pending && !wr_active && !stall;
    assign wready  = wr_active && !wr_done && !stall;
    assign wr_step = wvalid && wready;
    assign bvalid  = wr_done && (wr_cnt == 16'd0) && !stall;

    // burst ends on wlast or once the beat count runs out
    assign wr_end  = wr_step && (wlast || (wr_left == 8'd0));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_active <= 1'b0;
            rd_left   <= 8'd0;
            rd_cnt    <= 16'd0;
        end else if (!stall) begin
            if (rd_pop) begin
                rd_active <= 1'b1;
                rd_left   <= rd_head_len;
                rd_cnt    <= R_LOAD;
            end else begin
                if (rd_cnt != 16'd0)
                    rd_cnt <= rd_cnt - 16'd1;
                if (rd_step) begin
                    if (rlast)
                        rd_active <= 1'b0;
                    else
                        rd_left <= rd_left - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_active <= 1'b0;
            wr_left   <= 8'd0;
            wr_done   <= 1'b0;
            wr_cnt    <= 16'd0;
        end else if (!stall) begin
            if (wr_pop) begin
                wr_active <= 1'b1;
                wr_left   <= wr_head_len;
            end else if (wr_end) begin
                wr_done <= 1'b1;
                wr_cnt  <= W_LOAD;
            end else if (wr_step) begin
                wr_left <= wr_left - 8'd1;
            end else if (bvalid && bready) begin
                // response taken so the side goes idle
                wr_active <= 1'b0;
                wr_done   <= 1'b0;
            end else if (wr_done && wr_cnt != 16'd0) begin
                wr_cnt <= wr_cnt - 16'd1;
            end
        end
    end

endmodule

/* logic/burst_addr_gen.sv */
`timescale 1ns/1ps

module burst_addr_gen
    import axi_pkg::*;
    import ram_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  load,
    input  burst_desc_t           desc,
    input  logic                  step,
    output logic [ADDR_WIDTH-1:0] addr
);

    logic [ADDR_WIDTH-1:0] cur_addr;
    logic [LEN_WIDTH-1:0]  cur_len;
    logic [SIZE_WIDTH-1:0] cur_size;
    burst_e                cur_burst;
    logic [ADDR_WIDTH-1:0] step_addr;

    // current beat address straight from the register
    assign addr = cur_addr;

    // FIXED holds, INCR adds the beat size, WRAP folds inside its window
    assign step_addr = next_addr(cur_addr, cur_len, cur_size, cur_burst);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cur_addr  <= '0;
            cur_burst <= FIXED;
        end else if (load) begin
            cur_addr  <= desc.start_addr;
            cur_burst <= desc.burst;
        end else if (step) begin
            cur_addr  <= step_addr;
        end
    end

    // beat shape of the loaded burst
    always_ff @(posedge clk) begin
        if (load) begin
            cur_len  <= desc.len;
            cur_size <= desc.size;
        end
    end

endmodule

/* logic/req_queue.sv */
`timescale 1ns/1ps

module req_queue #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   full,
    output logic   not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t            slots [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = slots[rd_ptr];

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push)
            slots[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            if (do_push && !do_pop)
                count <= count + CNT_W'(1);
            else if (do_pop && !do_push)
                count <= count - CNT_W'(1);
        end
    end

endmodule

/* logic/ram_pkg.sv */
package ram_pkg;

    import axi_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // pending burst as held in the queues and generators
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [SIZE_WIDTH-1:0] size;
        burst_e                burst;
    } burst_desc_t;

    // address channel to descriptor at the queue input
    function automatic burst_desc_t to_desc(input addr_chan_t chan);
        burst_desc_t desc;
        desc.start_addr = chan.addr;
        desc.len        = chan.len;
        desc.size       = chan.size;
        desc.burst      = chan.burst;
        return desc;
    endfunction

endpackage

/* logic/axi_pkg.sv */
package axi_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int LEN_WIDTH  = 8;
    localparam int SIZE_WIDTH = 3;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // read or write address channel payload
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [SIZE_WIDTH-1:0] size;
        burst_e                burst;
    } addr_chan_t;

    // bytes moved per beat for a given size
    function automatic logic [ADDR_WIDTH-1:0] size_bytes(input logic [SIZE_WIDTH-1:0] size);
        size_bytes = ADDR_WIDTH'(1) << size;
    endfunction

    // wrap window in bytes as len + 1 beats of the beat size
    function automatic logic [ADDR_WIDTH-1:0] wrap_bytes(
        input logic [LEN_WIDTH-1:0]  len,
        input logic [SIZE_WIDTH-1:0] size
    );
        logic [ADDR_WIDTH-1:0] beats;
        beats = ADDR_WIDTH'(len) + ADDR_WIDTH'(1);
        wrap_bytes = beats << size;
    endfunction

    // next beat address following the AXI burst rules
    function automatic logic [ADDR_WIDTH-1:0] next_addr(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [LEN_WIDTH-1:0]  len,
        input logic [SIZE_WIDTH-1:0] size,
        input burst_e                burst
    );
        logic [ADDR_WIDTH-1:0] mask;
        logic [ADDR_WIDTH-1:0] incr;
        mask = wrap_bytes(len, size) - ADDR_WIDTH'(1);
        incr = addr + size_bytes(size);
        case (burst)
            INCR:    next_addr = incr;
            WRAP:    next_addr = (addr & ~mask) | (incr & mask);
            default: next_addr = addr;
        endcase
    endfunction

endpackage
